// File: rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

    // base widths of the integer ISA
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  funct3_t;

    localparam int num_regs = 32;

    // major opcodes
    localparam opcode_t op_lui    = 7'b0110111;
    localparam opcode_t op_auipc  = 7'b0010111;
    localparam opcode_t op_jal    = 7'b1101111;
    localparam opcode_t op_jalr   = 7'b1100111;
    localparam opcode_t op_imm    = 7'b0010011;
    localparam opcode_t op_reg    = 7'b0110011;
    localparam opcode_t op_load   = 7'b0000011;
    localparam opcode_t op_system = 7'b1110011;

    // minor opcodes and full words
    localparam funct3_t funct3_add  = 3'd0;
    localparam funct3_t funct3_lw   = 3'd2;
    localparam word_t   inst_ebreak = 32'h0010_0073;

    // immediate formats, all sign extended except U
    function automatic word_t imm_i(input word_t inst);
        return {{20{inst[31]}}, inst[31:20]};
    endfunction

    function automatic word_t imm_u(input word_t inst);
        return {inst[31:12], 12'b0};
    endfunction

    // J immediate is scrambled in the encoding, bit 0 is implicit zero
    function automatic word_t imm_j(input word_t inst);
        return {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
    endfunction

endpackage

`default_nettype wire

// File: npc_pkg.sv
`default_nettype none

package npc_pkg;

    // memory map
    localparam rv_isa_pkg::word_t reset_pc = 32'h8000_0000;
    localparam int mem_words = 1024;
    localparam int mem_addr_w = $clog2(mem_words);
    localparam rv_isa_pkg::word_t mem_bytes = mem_words * 4;

    typedef logic [mem_addr_w-1:0] mem_addr_t;

    // operation executed this cycle
    typedef enum logic [2:0] {
        op_nop,
        op_lui,
        op_auipc,
        op_jal,
        op_jalr,
        op_addi,
        op_add,
        op_lw
    } alu_op_e;

    // decoded control, one instruction
    typedef struct packed {
        alu_op_e              alu_op;
        logic                 reg_wen;
        logic                 mem_ren;
        rv_isa_pkg::reg_idx_t rd;
        rv_isa_pkg::reg_idx_t rs1;
        rv_isa_pkg::reg_idx_t rs2;
        rv_isa_pkg::word_t    imm;
        logic                 is_ebreak;
    } ctrl_t;

    // instruction completed this cycle
    typedef struct packed {
        logic                 wen;
        rv_isa_pkg::reg_idx_t rd;
        rv_isa_pkg::word_t    wdata;
        rv_isa_pkg::word_t    pc;
    } retire_t;

endpackage

`default_nettype wire

// File: pmem.sv
`timescale 1ns/1ps
`default_nettype none

module pmem (
    input  logic                  clk,
    input  logic                  load_en,
    input  npc_pkg::mem_addr_t    load_addr,
    input  rv_isa_pkg::word_t     load_data,
    input  rv_isa_pkg::word_t     fetch_addr,
    output rv_isa_pkg::word_t     inst,
    input  logic                  data_ren,
    input  rv_isa_pkg::word_t     data_addr,
    output rv_isa_pkg::word_t     rdata
);

    rv_isa_pkg::word_t  mem [npc_pkg::mem_words];
    npc_pkg::mem_addr_t fetch_idx;
    npc_pkg::mem_addr_t data_idx;
    logic               fetch_hit;
    logic               data_hit;

    // byte address relative to the start of the window
    function automatic rv_isa_pkg::word_t offset(input rv_isa_pkg::word_t addr);
        return addr - npc_pkg::reset_pc;
    endfunction

    function automatic logic in_window(input rv_isa_pkg::word_t addr);
        return offset(addr) < npc_pkg::mem_bytes;
    endfunction

    // low two bits dropped, word aligned
    function automatic npc_pkg::mem_addr_t word_index(input rv_isa_pkg::word_t addr);
        rv_isa_pkg::word_t off;
        off = offset(addr);
        return off[npc_pkg::mem_addr_w+1:2];
    endfunction

    assign fetch_hit = in_window(fetch_addr);
    assign fetch_idx = word_index(fetch_addr);
    assign data_hit  = in_window(data_addr);
    assign data_idx  = word_index(data_addr);

    // fetch port
    assign inst = fetch_hit ? mem[fetch_idx] : '0;

    // load port, zero when idle or out of range
    assign rdata = (data_ren && data_hit) ? mem[data_idx] : '0;

    // loader writes, used before the core runs
    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[load_addr] <= load_data;
        end
    end

endmodule

`default_nettype wire

// File: inst_decode.sv
`timescale 1ns/1ps
`default_nettype none

module inst_decode (
    input  rv_isa_pkg::word_t inst,
    output npc_pkg::ctrl_t    ctrl
);

    rv_isa_pkg::opcode_t  opcode;
    rv_isa_pkg::funct3_t  funct3;
    rv_isa_pkg::reg_idx_t rd;
    rv_isa_pkg::reg_idx_t rs1;
    rv_isa_pkg::reg_idx_t rs2;
    rv_isa_pkg::word_t    imm;
    npc_pkg::alu_op_e     alu_op;
    logic                 is_i;
    logic                 is_r;
    logic                 is_u;
    logic                 is_j;
    logic                 is_sys;

    // fixed field positions
    assign opcode = inst[6:0];
    assign rd     = inst[11:7];
    assign funct3 = inst[14:12];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];

    // format classes
    assign is_i = (opcode == rv_isa_pkg::op_imm)
                | (opcode == rv_isa_pkg::op_load)
                | (opcode == rv_isa_pkg::op_jalr);
    assign is_r = (opcode == rv_isa_pkg::op_reg);
    assign is_u = (opcode == rv_isa_pkg::op_lui)
                | (opcode == rv_isa_pkg::op_auipc);
    assign is_j = (opcode == rv_isa_pkg::op_jal);
    assign is_sys = (opcode == rv_isa_pkg::op_system);

    // immediate for the detected format, R type has none
    always_comb begin
        if (is_i) begin
            imm = rv_isa_pkg::imm_i(inst);
        end else if (is_u) begin
            imm = rv_isa_pkg::imm_u(inst);
        end else if (is_j) begin
            imm = rv_isa_pkg::imm_j(inst);
        end else begin
            imm = '0;
        end
    end

    // operation select
    always_comb begin
        alu_op = npc_pkg::op_nop;
        if (is_u) begin
            alu_op = (opcode == rv_isa_pkg::op_lui) ? npc_pkg::op_lui : npc_pkg::op_auipc;
        end else if (is_j) begin
            alu_op = npc_pkg::op_jal;
        end else if (is_r) begin
            if (funct3 == rv_isa_pkg::funct3_add) begin
                alu_op = npc_pkg::op_add;
            end
        end else if (is_i) begin
            case (opcode)
                // jalr shares funct3 zero with add
                rv_isa_pkg::op_jalr: begin
                    if (funct3 == rv_isa_pkg::funct3_add) begin
                        alu_op = npc_pkg::op_jalr;
                    end
                end
                rv_isa_pkg::op_imm: begin
                    if (funct3 == rv_isa_pkg::funct3_add) begin
                        alu_op = npc_pkg::op_addi;
                    end
                end
                default: begin
                    if (funct3 == rv_isa_pkg::funct3_lw) begin
                        alu_op = npc_pkg::op_lw;
                    end
                end
            endcase
        end
    end

    // pack control, anything not decoded writes nothing
    always_comb begin
        ctrl.alu_op    = alu_op;
        ctrl.reg_wen   = (alu_op != npc_pkg::op_nop);
        ctrl.mem_ren   = (alu_op == npc_pkg::op_lw);
        ctrl.rd        = rd;
        ctrl.rs1       = rs1;
        ctrl.rs2       = rs2;
        ctrl.imm       = imm;
        // exact word match, opcode checked separately
        ctrl.is_ebreak = is_sys && (inst[31:7] == rv_isa_pkg::inst_ebreak[31:7]);
    end

endmodule

`default_nettype wire

// File: alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  npc_pkg::ctrl_t    ctrl,
    input  rv_isa_pkg::word_t pc,
    input  rv_isa_pkg::word_t src1,
    input  rv_isa_pkg::word_t src2,
    input  rv_isa_pkg::word_t rdata,
    output rv_isa_pkg::word_t mem_addr,
    output rv_isa_pkg::word_t result,
    output rv_isa_pkg::word_t next_pc
);

    rv_isa_pkg::word_t pc_plus4;
    rv_isa_pkg::word_t pc_plus_imm;
    rv_isa_pkg::word_t base_plus_imm;

    assign pc_plus4      = pc + 32'd4;
    assign pc_plus_imm   = pc + ctrl.imm;
    // shared by load address and jalr target
    assign base_plus_imm = src1 + ctrl.imm;

    assign mem_addr = base_plus_imm;

    // register write value
    always_comb begin
        case (ctrl.alu_op)
            npc_pkg::op_lui:   result = ctrl.imm;
            npc_pkg::op_auipc: result = pc_plus_imm;
            npc_pkg::op_jal:   result = pc_plus4;
            npc_pkg::op_jalr:  result = pc_plus4;
            npc_pkg::op_addi:  result = base_plus_imm;
            npc_pkg::op_add:   result = src1 + src2;
            npc_pkg::op_lw:    result = rdata;
            default:           result = '0;
        endcase
    end

    // jumps redirect, everything else falls through
    always_comb begin
        case (ctrl.alu_op)
            npc_pkg::op_jal: begin
                next_pc = pc_plus_imm;
            end
            npc_pkg::op_jalr: begin
                next_pc = {base_plus_imm[31:1], 1'b0};
            end
            default: begin
                next_pc = pc_plus4;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: regfile.sv
`timescale 1ns/1ps
`default_nettype none

module regfile (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 wen,
    input  rv_isa_pkg::reg_idx_t waddr,
    input  rv_isa_pkg::word_t    wdata,
    input  rv_isa_pkg::reg_idx_t raddr1,
    input  rv_isa_pkg::reg_idx_t raddr2,
    output rv_isa_pkg::word_t    rdata1,
    output rv_isa_pkg::word_t    rdata2
);

    // x0 has no storage
    rv_isa_pkg::word_t regs [1:rv_isa_pkg::num_regs-1];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < rv_isa_pkg::num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && (waddr != '0)) begin
            regs[waddr] <= wdata;
        end
    end

    // combinational reads
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

// File: npc.sv
`timescale 1ns/1ps
`default_nettype none

module npc (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               load_en,
    input  npc_pkg::mem_addr_t load_addr,
    input  rv_isa_pkg::word_t  load_data,
    output rv_isa_pkg::word_t  pc,
    output npc_pkg::retire_t   retire,
    output logic               halted
);

    rv_isa_pkg::word_t inst;
    rv_isa_pkg::word_t src1;
    rv_isa_pkg::word_t src2;
    rv_isa_pkg::word_t rdata;
    rv_isa_pkg::word_t mem_addr;
    rv_isa_pkg::word_t result;
    rv_isa_pkg::word_t next_pc;
    npc_pkg::ctrl_t    ctrl;
    logic              running;
    logic              active;
    logic              commit;

    // one idle cycle after reset before the first retire
    assign active = running && !halted;
    assign commit = active && ctrl.reg_wen;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc      <= npc_pkg::reset_pc;
            halted  <= 1'b0;
            running <= 1'b0;
        end else begin
            running <= 1'b1;
            if (active) begin
                // ebreak parks pc at its own address
                if (ctrl.is_ebreak) begin
                    halted <= 1'b1;
                end else begin
                    pc <= next_pc;
                end
            end
        end
    end

    // write shown only when it commits
    always_comb begin
        retire.wen   = commit;
        retire.rd    = commit ? ctrl.rd : '0;
        retire.wdata = commit ? result : '0;
        retire.pc    = pc;
    end

    pmem u_pmem (
        .clk       (clk),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .fetch_addr(pc),
        .inst      (inst),
        .data_ren  (ctrl.mem_ren),
        .data_addr (mem_addr),
        .rdata     (rdata)
    );

    inst_decode u_inst_decode (
        .inst(inst),
        .ctrl(ctrl)
    );

    regfile u_regfile (
        .clk   (clk),
        .rst_n (rst_n),
        .wen   (commit),
        .waddr (ctrl.rd),
        .wdata (result),
        .raddr1(ctrl.rs1),
        .raddr2(ctrl.rs2),
        .rdata1(src1),
        .rdata2(src2)
    );

    alu u_alu (
        .ctrl    (ctrl),
        .pc      (pc),
        .src1    (src1),
        .src2    (src2),
        .rdata   (rdata),
        .mem_addr(mem_addr),
        .result  (result),
        .next_pc (next_pc)
    );

endmodule

`default_nettype wire

// File: tb_npc.sv
`timescale 1ns/1ps
`default_nettype none

module tb_npc;

    localparam int half_period     = 20;
    localparam int reset_cycles    = 10;
    localparam int halt_timeout    = 2000;
    localparam int release_timeout = npc_pkg::mem_words + 100;
    localparam int frozen_cycles   = 20;

    localparam rv_isa_pkg::reg_idx_t link_reg = 5'd1;
    localparam rv_isa_pkg::reg_idx_t base_reg = 5'd5;
    localparam rv_isa_pkg::reg_idx_t jump_reg = 5'd7;
    localparam rv_isa_pkg::reg_idx_t fill_reg = 5'd8;
    localparam rv_isa_pkg::opcode_t  op_store  = 7'b0100011;
    localparam rv_isa_pkg::opcode_t  op_branch = 7'b1100011;

    logic               clk;
    logic               rst_n;
    logic               load_en;
    npc_pkg::mem_addr_t load_addr;
    rv_isa_pkg::word_t  load_data;
    rv_isa_pkg::word_t  pc;
    npc_pkg::retire_t   retire;
    logic               halted;

    // reference model state whose memory image is also the loader source
    rv_isa_pkg::word_t ref_mem [npc_pkg::mem_words];
    rv_isa_pkg::word_t ref_regs [32];
    rv_isa_pkg::word_t ref_pc;
    logic              ref_halted;

    integer seed;
    int     prog_len      = 0;
    int     checks        = 0;
    int     word_errors   = 0;
    int     retire_errors = 0;
    int     bit_errors    = 0;
    int     timeouts      = 0;

    npc UUT (
        .clk      (clk),
        .rst_n    (rst_n),
        .load_en  (load_en),
        .load_addr(load_addr),
        .load_data(load_data),
        .pc       (pc),
        .retire   (retire),
        .halted   (halted)
    );

    initial begin
        clk = 1'b0;
        forever #(half_period) clk = ~clk;
    end

    function automatic int unsigned rand_below(input int unsigned n);
        int unsigned r;
        r = $random(seed);
        return r % n;
    endfunction

    // instruction encoders
    function automatic rv_isa_pkg::word_t enc_i(
        input rv_isa_pkg::opcode_t  opc,
        input rv_isa_pkg::funct3_t  f3,
        input rv_isa_pkg::reg_idx_t rd,
        input rv_isa_pkg::reg_idx_t rs1,
        input logic [11:0]          imm
    );
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic rv_isa_pkg::word_t enc_r(
        input rv_isa_pkg::opcode_t  opc,
        input rv_isa_pkg::funct3_t  f3,
        input rv_isa_pkg::reg_idx_t rd,
        input rv_isa_pkg::reg_idx_t rs1,
        input rv_isa_pkg::reg_idx_t rs2
    );
        return {7'b0, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic rv_isa_pkg::word_t enc_u(
        input rv_isa_pkg::opcode_t  opc,
        input rv_isa_pkg::reg_idx_t rd,
        input logic [19:0]          imm
    );
        return {imm, rd, opc};
    endfunction

    // offset bits are scattered over the upper word
    function automatic rv_isa_pkg::word_t enc_j(
        input rv_isa_pkg::reg_idx_t rd,
        input logic [20:0]          off
    );
        return {off[20], off[10:1], off[11], off[19:12], rd, rv_isa_pkg::op_jal};
    endfunction

    function automatic rv_isa_pkg::word_t fill_word(input int i);
        return 32'h6b1d_0000 ^ (rv_isa_pkg::word_t'(i) * 32'h0001_9e37);
    endfunction

    task automatic emit(input rv_isa_pkg::word_t w);
        ref_mem[npc_pkg::mem_addr_t'(prog_len)] = w;
        prog_len++;
    endtask

    task automatic emit_random_alu();
        logic [1:0]           kind;
        rv_isa_pkg::reg_idx_t rd;
        rv_isa_pkg::reg_idx_t rs1;
        rv_isa_pkg::reg_idx_t rs2;
        kind = 2'(rand_below(4));
        // x5 and x7 stay reserved for the load base and jump targets
        rd  = rv_isa_pkg::reg_idx_t'(8 + rand_below(24));
        rs1 = rv_isa_pkg::reg_idx_t'(rand_below(32));
        rs2 = rv_isa_pkg::reg_idx_t'(rand_below(32));
        case (kind)
            2'd0: emit(enc_u(rv_isa_pkg::op_lui, rd, 20'(rand_below(32'h10_0000))));
            2'd1: emit(enc_u(rv_isa_pkg::op_auipc, rd, 20'(rand_below(32'h10_0000))));
            2'd2: emit(enc_i(rv_isa_pkg::op_imm, rv_isa_pkg::funct3_add, rd, rs1,
                             12'(rand_below(4096))));
            default: emit(enc_r(rv_isa_pkg::op_reg, rv_isa_pkg::funct3_add, rd, rs1, rs2));
        endcase
    endtask

    task automatic build_image();
        int                   k;
        int                   off;
        rv_isa_pkg::reg_idx_t rd;
        for (int i = 0; i < npc_pkg::mem_words; i++) begin
            ref_mem[npc_pkg::mem_addr_t'(i)] = fill_word(i);
        end
        // x5 points at 0x80000a00 in the middle of the data words
        emit(enc_u(rv_isa_pkg::op_lui, base_reg, 20'h80001));
        emit(enc_i(rv_isa_pkg::op_imm, rv_isa_pkg::funct3_add, base_reg, base_reg, 12'ha00));
        repeat (24) emit_random_alu();
        // x0 writes show on retire but never stick
        emit(enc_i(rv_isa_pkg::op_imm, rv_isa_pkg::funct3_add, 5'd0, fill_reg, 12'h7ff));
        emit(enc_r(rv_isa_pkg::op_reg, rv_isa_pkg::funct3_add, 5'd9, 5'd0, 5'd0));
        emit(enc_i(rv_isa_pkg::op_imm, rv_isa_pkg::funct3_add, 5'd10, 5'd0, 12'hfff));
        repeat (8) begin
            rd  = rv_isa_pkg::reg_idx_t'(8 + rand_below(24));
            off = (int'(rand_below(128)) - 64) * 4;
            emit(enc_i(rv_isa_pkg::op_load, rv_isa_pkg::funct3_lw, rd, base_reg, 12'(off)));
        end
        // sw, xori, beq, lb and ecall are not executed
        emit(enc_r(op_store, 3'd2, 5'd3, base_reg, 5'd12));
        emit(enc_i(rv_isa_pkg::op_imm, 3'd4, 5'd11, 5'd12, 12'h0f0));
        emit(enc_r(op_branch, 3'd0, 5'd8, 5'd13, 5'd14));
        emit(enc_i(rv_isa_pkg::op_load, 3'd0, 5'd15, base_reg, 12'd0));
        emit(32'h0000_0073);
        // forward jal over k-1 filler words
        k = 2 + int'(rand_below(3));
        emit(enc_j(link_reg, 21'(k * 4)));
        repeat (k - 1) emit(enc_i(rv_isa_pkg::op_imm, rv_isa_pkg::funct3_add,
                                  fill_reg, fill_reg, 12'd1));
        // jalr with odd positive offset lands three words on
        emit(enc_u(rv_isa_pkg::op_auipc, jump_reg, 20'd0));
        emit(enc_i(rv_isa_pkg::op_jalr, rv_isa_pkg::funct3_add, link_reg, jump_reg, 12'd13));
        emit(enc_i(rv_isa_pkg::op_imm, rv_isa_pkg::funct3_add, fill_reg, fill_reg, 12'd1));
        // jalr with negative offset and odd sum lands four words on
        emit(enc_u(rv_isa_pkg::op_auipc, jump_reg, 20'd0));
        emit(enc_i(rv_isa_pkg::op_imm, rv_isa_pkg::funct3_add, jump_reg, jump_reg, 12'h7ff));
        emit(enc_i(rv_isa_pkg::op_jalr, rv_isa_pkg::funct3_add, 5'd16, jump_reg, 12'(-2030)));
        emit(enc_i(rv_isa_pkg::op_imm, rv_isa_pkg::funct3_add, fill_reg, fill_reg, 12'd1));
        repeat (8) emit_random_alu();
        emit(rv_isa_pkg::inst_ebreak);
    endtask

    // 4 KiB window starting at the reset pc
    function automatic rv_isa_pkg::word_t mem_read(input rv_isa_pkg::word_t addr);
        rv_isa_pkg::word_t off;
        off = addr - npc_pkg::reset_pc;
        if (off >= 32'd4096) begin
            return '0;
        end
        return ref_mem[off[11:2]];
    endfunction

    // executes the instruction at ref_pc and returns what should retire
    function automatic npc_pkg::retire_t ref_step();
        rv_isa_pkg::word_t    inst;
        rv_isa_pkg::word_t    imm_i;
        rv_isa_pkg::word_t    imm_u;
        rv_isa_pkg::word_t    imm_j;
        rv_isa_pkg::word_t    src1;
        rv_isa_pkg::word_t    src2;
        rv_isa_pkg::word_t    wdata;
        rv_isa_pkg::word_t    next_pc;
        rv_isa_pkg::reg_idx_t rd;
        logic                 wen;
        logic                 stop;
        npc_pkg::retire_t     exp;
        inst    = mem_read(ref_pc);
        rd      = inst[11:7];
        src1    = ref_regs[inst[19:15]];
        src2    = ref_regs[inst[24:20]];
        imm_i   = {{20{inst[31]}}, inst[31:20]};
        imm_u   = {inst[31:12], 12'h000};
        imm_j   = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
        wen     = 1'b0;
        stop    = 1'b0;
        wdata   = '0;
        next_pc = ref_pc + 32'd4;
        if (!ref_halted) begin
            case (inst[6:0])
                rv_isa_pkg::op_lui: begin
                    wen   = 1'b1;
                    wdata = imm_u;
                end
                rv_isa_pkg::op_auipc: begin
                    wen   = 1'b1;
                    wdata = ref_pc + imm_u;
                end
                rv_isa_pkg::op_jal: begin
                    wen     = 1'b1;
                    wdata   = ref_pc + 32'd4;
                    next_pc = ref_pc + imm_j;
                end
                rv_isa_pkg::op_jalr: begin
                    if (inst[14:12] == rv_isa_pkg::funct3_add) begin
                        wen     = 1'b1;
                        wdata   = ref_pc + 32'd4;
                        next_pc = (src1 + imm_i) & 32'hffff_fffe;
                    end
                end
                rv_isa_pkg::op_imm: begin
                    wen   = (inst[14:12] == rv_isa_pkg::funct3_add);
                    wdata = src1 + imm_i;
                end
                rv_isa_pkg::op_reg: begin
                    wen   = (inst[14:12] == rv_isa_pkg::funct3_add);
                    wdata = src1 + src2;
                end
                rv_isa_pkg::op_load: begin
                    wen   = (inst[14:12] == rv_isa_pkg::funct3_lw);
                    wdata = mem_read(src1 + imm_i);
                end
                rv_isa_pkg::op_system: begin
                    stop = (inst == rv_isa_pkg::inst_ebreak);
                end
                default: begin
                    wen = 1'b0;
                end
            endcase
        end
        exp.wen   = wen;
        exp.rd    = wen ? rd : '0;
        exp.wdata = wen ? wdata : '0;
        exp.pc    = ref_pc;
        if (!ref_halted) begin
            if (wen && (rd != 5'd0)) begin
                ref_regs[rd] = wdata;
            end
            if (stop) begin
                ref_halted = 1'b1;
            end else begin
                ref_pc = next_pc;
            end
        end
        return exp;
    endfunction

    task automatic check_word(input string name, input rv_isa_pkg::word_t got,
                              input rv_isa_pkg::word_t exp);
        checks++;
        if (got !== exp) begin
            word_errors++;
            $display("error at %0d ns: %s got %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            bit_errors++;
            $display("error at %0d ns: %s got %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_retire(input npc_pkg::retire_t got, input npc_pkg::retire_t exp);
        checks++;
        if (got.wen !== exp.wen) begin
            retire_errors++;
            $display("error at %0d ns: retire.wen got %b, expected %b", $time, got.wen, exp.wen);
        end
        if (got.rd !== exp.rd) begin
            retire_errors++;
            $display("error at %0d ns: retire.rd got %0d, expected %0d", $time, got.rd, exp.rd);
        end
        if (got.wdata !== exp.wdata) begin
            retire_errors++;
            $display("error at %0d ns: retire.wdata got %h, expected %h",
                     $time, got.wdata, exp.wdata);
        end
        if (got.pc !== exp.pc) begin
            retire_errors++;
            $display("error at %0d ns: retire.pc got %h, expected %h", $time, got.pc, exp.pc);
        end
    endtask

    task automatic compare_cycle();
        rv_isa_pkg::word_t exp_pc;
        logic              exp_halted;
        npc_pkg::retire_t  exp;
        exp_pc     = ref_pc;
        exp_halted = ref_halted;
        exp        = ref_step();
        check_word("pc", pc, exp_pc);
        check_retire(retire, exp);
        check_bit("halted", halted, exp_halted);
    endtask

    initial begin : stimulus
        rst_n     = 1'b0;
        load_en   = 1'b0;
        load_addr = '0;
        load_data = '0;
        seed      = 32'h91478aa7;
        for (int i = 0; i < 32; i++) begin
            ref_regs[rv_isa_pkg::reg_idx_t'(i)] = '0;
        end
        ref_pc     = npc_pkg::reset_pc;
        ref_halted = 1'b0;
        build_image();
        for (int i = 0; i < npc_pkg::mem_words; i++) begin
            @(negedge clk);
            load_en   = 1'b1;
            load_addr = npc_pkg::mem_addr_t'(i);
            load_data = ref_mem[npc_pkg::mem_addr_t'(i)];
        end
        @(negedge clk);
        load_en = 1'b0;
        repeat (reset_cycles) @(negedge clk);
        rst_n = 1'b1;
        // first cycle after release is idle and retires nothing
        #(half_period / 2);
        check_word("pc", pc, npc_pkg::reset_pc);
        check_bit("retire.wen", retire.wen, 1'b0);
        check_bit("halted", halted, 1'b0);
    end

    initial begin : compare
        int n;
        n = 0;
        while ((rst_n !== 1'b1) && (n < release_timeout)) begin
            @(posedge clk);
            n++;
        end
        if (rst_n !== 1'b1) begin
            timeouts++;
            $display("reset was never released, stopping the run");
        end else begin
            // first sample lands after the idle edge with pc still at reset
            n = 0;
            @(negedge clk);
            while ((halted !== 1'b1) && (n < halt_timeout)) begin
                compare_cycle();
                n++;
                @(negedge clk);
            end
            if (halted !== 1'b1) begin
                timeouts++;
                $display("core did not halt within %0d cycles", halt_timeout);
            end else begin
                repeat (frozen_cycles) begin
                    compare_cycle();
                    @(negedge clk);
                end
            end
        end
        $display("checks %0d, errors: pc %0d, retire %0d, flags %0d, timeouts %0d",
                 checks, word_errors, retire_errors, bit_errors, timeouts);
        if ((word_errors + retire_errors + bit_errors + timeouts) == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: npc.f
rv_isa_pkg.sv
npc_pkg.sv
pmem.sv
inst_decode.sv
alu.sv
regfile.sv
npc.sv
tb_npc.sv

// File: run_sim.sh
#!/bin/sh
# build and run the npc testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --timescale 1ns/1ps \
    --top-module tb_npc -f npc.f -o tb_npc_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_npc_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# the testbench prints its verdict into the log
if grep -q "test failed" "$log"; then
    echo "simulation reported failure"
    exit 1
fi

exit 0
